//--- include/dmac_defs.svh
`ifndef DMAC_DEFS_SVH
`define DMAC_DEFS_SVH

// FIFO entries, power of two
`define DMAC_FIFO_DEPTH 8

// Cycles each peripheral strobe is held
`define DMAC_PORT_CYCLES 3

// Host register address width
`define DMAC_REG_ADDR_W 3

`endif

//--- src/dmacPkg.sv
`include "dmac_defs.svh"

package dmacPkg;

    typedef logic [7:0]  byteT;     // Peripheral port byte
    typedef logic [31:0] wordT;     // Host bus word
    typedef logic [3:0]  byteEnT;   // One bit per memory lane

    // Byte plus end-of-transfer marker
    typedef struct packed {
        logic last;
        byteT data;
    } fifoEntryT;

    typedef enum logic [`DMAC_REG_ADDR_W-1:0] {
        CTRL   = 3'd0,
        ADDR   = 3'd1,
        COUNT  = 3'd2,
        STATUS = 3'd3,
        WINDOW = 3'd4
    } regIdxE;

endpackage

//--- src/portBusIf.sv
`timescale 1ns/1ps

interface portBusIf;
    import dmacPkg::*;

    logic valid;
    logic ready;    // Single-cycle pulse, ends the request
    logic write;
    logic dack;     // High selects DACK, low selects chip CS
    byteT wdata;
    byteT rdata;

    modport requester (
        output valid, write, dack, wdata,
        input  ready, rdata
    );

    modport arbiter (
        input  valid, write, dack, wdata,
        output ready, rdata
    );

endinterface

//--- src/portArbiter.sv
`timescale 1ns/1ps
`include "dmac_defs.svh"

module portArbiter (
    input  logic          nSCLK,
    input  logic          nAS_,
    portBusIf.arbiter     cpuPort,
    portBusIf.arbiter     dmaPort,
    input  dmacPkg::byteT pdData_i,
    output dmacPkg::byteT pdData_o,
    output logic          pdRead_o,
    output logic          pdWrite_o,
    output logic          pdCs_o,
    output logic          pdDack_o
);
    import dmacPkg::*;

    localparam int CNT_W = $clog2(`DMAC_PORT_CYCLES + 1);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_STROBE,
        ARB_ACK
    } arbStateE;

    arbStateE         state;
    logic             grantCpu;    // Owner of the current access
    logic [CNT_W-1:0] strobeCnt;
    logic             strobing;
    logic             grantWrite;
    logic             grantDack;
    byteT             rdataQ;

    assign strobing   = (state == ARB_STROBE);
    assign grantWrite = grantCpu ? cpuPort.write : dmaPort.write;
    assign grantDack  = grantCpu ? cpuPort.dack : dmaPort.dack;

    assign pdRead_o  = strobing && !grantWrite;
    assign pdWrite_o = strobing && grantWrite;
    assign pdCs_o    = strobing && !grantDack;
    assign pdDack_o  = strobing && grantDack;
    assign pdData_o  = grantCpu ? cpuPort.wdata : dmaPort.wdata;

    assign cpuPort.ready = (state == ARB_ACK) && grantCpu;
    assign dmaPort.ready = (state == ARB_ACK) && !grantCpu;
    assign cpuPort.rdata = rdataQ;
    assign dmaPort.rdata = rdataQ;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state     <= ARB_IDLE;
            grantCpu  <= 1'b0;
            strobeCnt <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (cpuPort.valid || dmaPort.valid) begin
                        grantCpu  <= cpuPort.valid;    // CPU window wins a tie
                        strobeCnt <= '0;
                        state     <= ARB_STROBE;
                    end
                end
                ARB_STROBE: begin
                    strobeCnt <= strobeCnt + 1'b1;
                    if (strobeCnt == CNT_W'(`DMAC_PORT_CYCLES - 1)) begin
                        state <= ARB_ACK;
                    end
                end
                default: state <= ARB_IDLE;    // ACK lasts one cycle
            endcase
        end
    end

    // Sample the chip on the last strobe cycle
    always_ff @(posedge nSCLK) begin
        if (strobing && strobeCnt == CNT_W'(`DMAC_PORT_CYCLES - 1)) begin
            rdataQ <= pdData_i;
        end
    end

endmodule

//--- src/dmaRegisters.sv
`timescale 1ns/1ps
`include "dmac_defs.svh"

module dmaRegisters (
    input  logic                        nSCLK,
    input  logic                        nAS_,
    input  logic                        regValid_i,
    input  logic                        regWrite_i,
    input  logic [`DMAC_REG_ADDR_W-1:0] regAddr_i,
    input  dmacPkg::wordT               regWdata_i,
    output logic                        regReady_o,
    output dmacPkg::wordT               regRdata_o,
    portBusIf.requester                 windowPort,
    input  logic                        scsiInt_i,
    input  logic                        xferDone_i,
    input  logic                        fifoEmpty_i,
    output logic                        start_o,
    output dmacPkg::wordT               startAddr_o,
    output dmacPkg::wordT               byteCount_o,
    output logic                        irq_o
);
    import dmacPkg::*;

    regIdxE regIdx;
    logic   accept;      // Host access taken this cycle
    logic   winDone;
    logic   intEn;
    logic   busy;
    logic   done;
    wordT   readMux;

    assign regIdx  = regIdxE'(regAddr_i);
    assign accept  = regValid_i && !regReady_o && !windowPort.valid;
    assign winDone = windowPort.valid && windowPort.ready;
    assign irq_o   = intEn && (done || scsiInt_i);

    assign windowPort.dack = 1'b0;    // Window always targets chip CS

    always_comb begin
        case (regIdx)
            CTRL:    readMux = {29'd0, intEn, 2'b00};    // Start reads back as zero
            ADDR:    readMux = startAddr_o;
            COUNT:   readMux = byteCount_o;
            STATUS:  readMux = {29'd0, scsiInt_i, done, busy};
            default: readMux = '0;
        endcase
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            regReady_o       <= 1'b0;
            windowPort.valid <= 1'b0;
            start_o          <= 1'b0;
            intEn            <= 1'b0;
            busy             <= 1'b0;
            done             <= 1'b0;
            startAddr_o      <= '0;
            byteCount_o      <= '0;
        end else begin
            regReady_o <= 1'b0;
            start_o    <= 1'b0;
            if (winDone) begin
                windowPort.valid <= 1'b0;
                regReady_o       <= 1'b1;    // Host waits out the port access
            end
            if (accept) begin
                if (regIdx == WINDOW) begin
                    windowPort.valid <= 1'b1;
                end else begin
                    regReady_o <= 1'b1;
                end
                if (regWrite_i) begin
                    case (regIdx)
                        CTRL: begin
                            intEn <= regWdata_i[2];
                            if (regWdata_i[0] && byteCount_o != '0 && !busy && fifoEmpty_i) begin
                                start_o <= 1'b1;
                                busy    <= 1'b1;
                                done    <= 1'b0;
                            end
                        end
                        ADDR:    startAddr_o <= regWdata_i;
                        COUNT:   byteCount_o <= regWdata_i;
                        STATUS: begin
                            if (regWdata_i[1]) begin
                                done <= 1'b0;    // Write one to clear
                            end
                        end
                        default: ;
                    endcase
                end
            end
            if (xferDone_i) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge nSCLK) begin
        if (winDone) begin
            regRdata_o <= {24'd0, windowPort.rdata};
        end else if (accept && regIdx != WINDOW) begin
            regRdata_o <= readMux;
        end
        if (accept && regIdx == WINDOW) begin
            windowPort.write <= regWrite_i;
            windowPort.wdata <= regWdata_i[7:0];
        end
    end

endmodule

//--- src/byteFifo.sv
`timescale 1ns/1ps
`include "dmac_defs.svh"

module byteFifo (
    input  logic               nSCLK,
    input  logic               nAS_,
    input  logic               push_i,
    input  dmacPkg::fifoEntryT pushEntry_i,
    output logic               full_o,
    input  logic               pop_i,
    output dmacPkg::fifoEntryT popEntry_o,
    output logic               empty_o
);
    import dmacPkg::*;

    localparam int DEPTH = `DMAC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fifoEntryT        mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;    // One extra bit to tell full from empty
    logic             doPush;
    logic             doPop;

    assign doPush     = push_i && !full_o;
    assign doPop      = pop_i && !empty_o;
    assign full_o     = (count == (PTR_W + 1)'(DEPTH));
    assign empty_o    = (count == '0);
    assign popEntry_o = mem[rdPtr];    // Head is visible before the pop

    always_ff @(posedge nSCLK) begin
        if (doPush) begin
            mem[wrPtr] <= pushEntry_i;
        end
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;    // Wraps at DEPTH
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- src/scsiDmaEngine.sv
`timescale 1ns/1ps

module scsiDmaEngine (
    input  logic               nSCLK,
    input  logic               nAS_,
    input  logic               start_i,
    input  dmacPkg::wordT      byteCount_i,
    input  logic               drq_i,
    input  logic               fifoFull_i,
    portBusIf.requester        dmaPort,
    output logic               push_o,
    output dmacPkg::fifoEntryT pushEntry_o
);
    import dmacPkg::*;

    wordT remaining;    // Bytes still to fetch
    logic byteDone;

    assign byteDone = dmaPort.valid && dmaPort.ready;

    // DMA side only reads through DACK
    assign dmaPort.write = 1'b0;
    assign dmaPort.dack  = 1'b1;
    assign dmaPort.wdata = '0;

    // Returned byte goes straight into the FIFO
    assign push_o      = byteDone;
    assign pushEntry_o = '{last: (remaining == 32'd1), data: dmaPort.rdata};

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            remaining     <= '0;
            dmaPort.valid <= 1'b0;
        end else if (start_i) begin
            remaining     <= byteCount_i;
            dmaPort.valid <= 1'b0;
        end else if (byteDone) begin
            dmaPort.valid <= 1'b0;
            remaining     <= remaining - 32'd1;
        end else if (!dmaPort.valid && remaining != '0 && drq_i && !fifoFull_i) begin
            // One byte in flight at most, so a free slot stays free
            dmaPort.valid <= 1'b1;
        end
    end

endmodule

//--- src/busMaster.sv
`timescale 1ns/1ps

module busMaster (
    input  logic               nSCLK,
    input  logic               nAS_,
    input  logic               start_i,
    input  dmacPkg::wordT      startAddr_i,
    output logic               pop_o,
    input  dmacPkg::fifoEntryT popEntry_i,
    input  logic               empty_i,
    output logic               memValid_o,
    input  logic               memReady_i,
    output dmacPkg::wordT      memAddr_o,
    output dmacPkg::wordT      memData_o,
    output dmacPkg::byteEnT    memByteEn_o,
    output logic               xferDone_o
);
    import dmacPkg::*;

    logic [1:0] lane;          // Next lane to fill
    logic       lastPending;   // Word in flight ends the transfer
    logic       accepted;
    logic       wordFull;

    // Packing stops while a word waits on the bus
    assign pop_o    = !memValid_o && !empty_i;
    assign accepted = memValid_o && memReady_i;
    assign wordFull = (lane == 2'd3) || popEntry_i.last;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            memValid_o  <= 1'b0;
            memByteEn_o <= '0;
            lane        <= 2'd0;
            lastPending <= 1'b0;
            xferDone_o  <= 1'b0;
        end else begin
            xferDone_o <= 1'b0;
            if (start_i) begin
                memByteEn_o <= '0;
                lane        <= 2'd0;
                lastPending <= 1'b0;
            end else if (accepted) begin
                memValid_o  <= 1'b0;
                memByteEn_o <= '0;
                if (lastPending) begin
                    xferDone_o  <= 1'b1;
                    lastPending <= 1'b0;
                end
            end else if (pop_o) begin
                memByteEn_o[lane] <= 1'b1;
                memValid_o        <= wordFull;
                lane              <= popEntry_i.last ? 2'd0 : lane + 2'd1;
                if (popEntry_i.last) begin
                    lastPending <= 1'b1;
                end
            end
        end
    end

    // Lane k of the word holds byte k, little-endian
    always_ff @(posedge nSCLK) begin
        if (start_i) begin
            memAddr_o <= startAddr_i;
            memData_o <= '0;
        end else if (accepted) begin
            memAddr_o <= memAddr_o + 32'd4;
            memData_o <= '0;    // Unused lanes of a short word stay zero
        end else if (pop_o) begin
            memData_o[8*lane +: 8] <= popEntry_i.data;
        end
    end

endmodule

//--- src/resdmac.sv
`timescale 1ns/1ps
`include "dmac_defs.svh"

module resdmac (
    input  logic                        nSCLK,
    input  logic                        nAS_,
    input  logic                        regValid_i,
    input  logic                        regWrite_i,
    input  logic [`DMAC_REG_ADDR_W-1:0] regAddr_i,
    input  dmacPkg::wordT               regWdata_i,
    output logic                        regReady_o,
    output dmacPkg::wordT               regRdata_o,
    output logic                        memValid_o,
    input  logic                        memReady_i,
    output dmacPkg::wordT               memAddr_o,
    output dmacPkg::wordT               memData_o,
    output dmacPkg::byteEnT             memByteEn_o,
    input  dmacPkg::byteT               pdData_i,
    output dmacPkg::byteT               pdData_o,
    output logic                        pdRead_o,
    output logic                        pdWrite_o,
    output logic                        pdCs_o,
    output logic                        pdDack_o,
    input  logic                        drq_i,
    input  logic                        scsiInt_i,
    output logic                        irq_o
);
    import dmacPkg::*;

    logic      startPulse;
    wordT      startAddr;
    wordT      byteCount;
    logic      xferDone;
    logic      fifoFull;
    logic      fifoEmpty;
    logic      push;
    fifoEntryT pushEntry;
    logic      pop;
    fifoEntryT popEntry;

    portBusIf windowBus ();    // CPU access to the chip register
    portBusIf dmaBus ();       // DACK byte reads

    dmaRegisters uRegisters (
        .nSCLK       (nSCLK      ),
        .nAS_        (nAS_       ),
        .regValid_i  (regValid_i ),
        .regWrite_i  (regWrite_i ),
        .regAddr_i   (regAddr_i  ),
        .regWdata_i  (regWdata_i ),
        .regReady_o  (regReady_o ),
        .regRdata_o  (regRdata_o ),
        .windowPort  (windowBus  ),
        .scsiInt_i   (scsiInt_i  ),
        .xferDone_i  (xferDone   ),
        .fifoEmpty_i (fifoEmpty  ),
        .start_o     (startPulse ),
        .startAddr_o (startAddr  ),
        .byteCount_o (byteCount  ),
        .irq_o       (irq_o      )
    );

    scsiDmaEngine uEngine (
        .nSCLK       (nSCLK      ),
        .nAS_        (nAS_       ),
        .start_i     (startPulse ),
        .byteCount_i (byteCount  ),
        .drq_i       (drq_i      ),
        .fifoFull_i  (fifoFull   ),
        .dmaPort     (dmaBus     ),
        .push_o      (push       ),
        .pushEntry_o (pushEntry  )
    );

    byteFifo uFifo (
        .nSCLK       (nSCLK      ),
        .nAS_        (nAS_       ),
        .push_i      (push       ),
        .pushEntry_i (pushEntry  ),
        .full_o      (fifoFull   ),
        .pop_i       (pop        ),
        .popEntry_o  (popEntry   ),
        .empty_o     (fifoEmpty  )
    );

    busMaster uMaster (
        .nSCLK       (nSCLK      ),
        .nAS_        (nAS_       ),
        .start_i     (startPulse ),
        .startAddr_i (startAddr  ),
        .pop_o       (pop        ),
        .popEntry_i  (popEntry   ),
        .empty_i     (fifoEmpty  ),
        .memValid_o  (memValid_o ),
        .memReady_i  (memReady_i ),
        .memAddr_o   (memAddr_o  ),
        .memData_o   (memData_o  ),
        .memByteEn_o (memByteEn_o),
        .xferDone_o  (xferDone   )
    );

    portArbiter uArbiter (
        .nSCLK     (nSCLK    ),
        .nAS_      (nAS_     ),
        .cpuPort   (windowBus),
        .dmaPort   (dmaBus   ),
        .pdData_i  (pdData_i ),
        .pdData_o  (pdData_o ),
        .pdRead_o  (pdRead_o ),
        .pdWrite_o (pdWrite_o),
        .pdCs_o    (pdCs_o   ),
        .pdDack_o  (pdDack_o )
    );

endmodule

//--- tests/tbResdmac.sv
`timescale 1ns/1ps
`include "dmac_defs.svh"

module tbResdmac;
    import dmacPkg::*;

    localparam int REG_TIMEOUT = 200;    // Cycles allowed per host access
    localparam int DONE_POLLS  = 500;
    localparam int STREAM_LEN  = 1024;

    logic                        nSCLK = 1'b0;
    logic                        nAS_;
    logic                        regValid;
    logic                        regWrite;
    logic [`DMAC_REG_ADDR_W-1:0] regAddr;
    wordT                        regWdata;
    logic                        regReady;
    wordT                        regRdata;
    logic                        memValid;
    logic                        memReady;
    wordT                        memAddr;
    wordT                        memData;
    byteEnT                      memByteEn;
    byteT                        pdDataIn;
    byteT                        pdDataOut;
    logic                        pdRead;
    logic                        pdWrite;
    logic                        pdCs;
    logic                        pdDack;
    logic                        drq;
    logic                        scsiInt;
    logic                        irq;

    integer seed = 36;
    int     errors;
    int     strobeErrors;    // Owned by the chip model
    int     testsRun;
    int     testsFailed;
    int     errAtStart;
    logic   hung;            // A wait ran out, later accesses are skipped
    string  curTest;

    byteT   streamMem [STREAM_LEN];    // DACK byte stream, consumed in order
    int     dackCount;
    byteT   chipReg;

    wordT   memArr [wordT];
    wordT   logAddr [$];
    byteEnT logEn [$];
    wordT   expAddr [$];
    wordT   expData [$];
    byteEnT expEn [$];

    resdmac dut (
        .nSCLK       (nSCLK    ),
        .nAS_        (nAS_     ),
        .regValid_i  (regValid ),
        .regWrite_i  (regWrite ),
        .regAddr_i   (regAddr  ),
        .regWdata_i  (regWdata ),
        .regReady_o  (regReady ),
        .regRdata_o  (regRdata ),
        .memValid_o  (memValid ),
        .memReady_i  (memReady ),
        .memAddr_o   (memAddr  ),
        .memData_o   (memData  ),
        .memByteEn_o (memByteEn),
        .pdData_i    (pdDataIn ),
        .pdData_o    (pdDataOut),
        .pdRead_o    (pdRead   ),
        .pdWrite_o   (pdWrite  ),
        .pdCs_o      (pdCs     ),
        .pdDack_o    (pdDack   ),
        .drq_i       (drq      ),
        .scsiInt_i   (scsiInt  ),
        .irq_o       (irq      )
    );

    always #5 nSCLK = ~nSCLK;

    // Background value of memory never written
    function automatic wordT fillWord(input wordT a);
        return a ^ 32'hC3A5_5A3C ^ {a[15:0], a[31:16]};
    endfunction

    function automatic wordT readMem(input wordT a);
        return memArr.exists(a) ? memArr[a] : fillWord(a);
    endfunction

    // Random DRQ and memory back-pressure
    initial begin : busDrive
        logic [31:0] r;
        drq      = 1'b0;
        memReady = 1'b0;
        forever begin
            @(posedge nSCLK);
            #1;
            r        = $random(seed);
            drq      = (r[1:0] != 2'b00);    // About three cycles in four
            memReady = r[4];
        end
    end

    // SCSI chip, one register on CS plus the DACK byte stream
    initial begin : chipModel
        int strobeLen;
        pdDataIn  = '0;
        chipReg   = '0;
        dackCount = 0;
        strobeLen = 0;
        strobeErrors = 0;
        forever begin
            @(posedge nSCLK);
            #1;
            if (pdCs || pdDack) begin
                if (strobeLen == 0 && pdRead) begin
                    if (pdDack) begin
                        pdDataIn  = streamMem[dackCount % STREAM_LEN];
                        dackCount = dackCount + 1;
                    end else begin
                        pdDataIn = chipReg;
                    end
                end
                if (pdWrite && pdCs) chipReg = pdDataOut;
                strobeLen = strobeLen + 1;
            end else begin
                if (strobeLen != 0 && strobeLen != `DMAC_PORT_CYCLES) begin
                    $display("peripheral strobe held %0d cycles instead of %0d",
                             strobeLen, `DMAC_PORT_CYCLES);
                    strobeErrors = strobeErrors + 1;
                end
                strobeLen = 0;
            end
        end
    end

    // Memory slave, records accepted writes and merges lanes
    always @(posedge nSCLK) begin : memModel
        wordT merged;
        if (nAS_ && memValid && memReady) begin
            merged = readMem(memAddr);
            for (int k = 0; k < 4; k++) begin
                if (memByteEn[k]) merged[8*k +: 8] = memData[8*k +: 8];
            end
            memArr[memAddr] = merged;
            logAddr.push_back(memAddr);
            logEn.push_back(memByteEn);
        end
    end

    task automatic checkWord(input string what, input wordT exp, input wordT act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %08h, actual %08h", curTest, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkByteEn(input string what, input byteEnT exp, input byteEnT act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %04b, actual %04b", curTest, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkByte(input string what, input byteT exp, input byteT act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %02h, actual %02h", curTest, what, exp, act);
            errors++;
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %0b, actual %0b", curTest, what, exp, act);
            errors++;
        end
    endtask

    // One host access, latency counted from the edge that sees valid
    task automatic regAccess(input logic wr, input logic [`DMAC_REG_ADDR_W-1:0] idx,
                             input wordT wdata, output wordT rdata, output int latency);
        int n;
        rdata   = '0;
        latency = 0;
        if (hung) return;
        @(posedge nSCLK);
        #1;
        regValid = 1'b1;
        regWrite = wr;
        regAddr  = idx;
        regWdata = wdata;
        n = 0;
        while (!regReady && n < REG_TIMEOUT) begin
            @(posedge nSCLK);
            #1;
            n++;
        end
        regValid = 1'b0;
        if (!regReady) begin
            $display("host access to register %0d got no ready within %0d cycles",
                     idx, REG_TIMEOUT);
            errors++;
            hung = 1'b1;
        end else begin
            rdata   = regRdata;
            latency = n - 1;
        end
    endtask

    task automatic writeReg(input logic [`DMAC_REG_ADDR_W-1:0] idx, input wordT wdata);
        wordT unused;
        int   lat;
        regAccess(1'b1, idx, wdata, unused, lat);
    endtask

    task automatic readReg(input logic [`DMAC_REG_ADDR_W-1:0] idx, output wordT rdata);
        int lat;
        regAccess(1'b0, idx, '0, rdata, lat);
    endtask

    task automatic windowExercise();
        byteT b;
        wordT rd;
        b = byteT'($random(seed));
        writeReg(WINDOW, {24'd0, b});
        checkByte("chip register after window write", b, chipReg);
        readReg(WINDOW, rd);
        checkByte("window read", b, rd[7:0]);
    endtask

    // Expected words from the stream, start address and count
    task automatic buildExpected(input wordT base, input int count, input int first);
        int     nWords;
        wordT   a;
        wordT   d;
        byteEnT en;
        expAddr.delete();
        expData.delete();
        expEn.delete();
        nWords = (count + 3) / 4;
        for (int w = 0; w < nWords; w++) begin
            a  = base + 32'(4 * w);
            d  = fillWord(a);
            en = '0;
            for (int k = 0; k < 4; k++) begin
                if (4 * w + k < count) begin
                    en[k]        = 1'b1;
                    d[8*k +: 8]  = streamMem[(first + 4 * w + k) % STREAM_LEN];
                end
            end
            expAddr.push_back(a);
            expData.push_back(d);
            expEn.push_back(en);
        end
    endtask

    task automatic runTransfer(input int region, input int count, input logic intEn,
                               input logic withWindow);
        wordT base;
        wordT st;
        int   first;
        int   logBase;
        int   polls;
        base    = (32'(region) << 16) | (wordT'($random(seed)) & 32'h0000_FFC0);
        first   = dackCount;
        logBase = logAddr.size();
        buildExpected(base, count, first);
        writeReg(ADDR, base);
        writeReg(COUNT, wordT'(count));
        writeReg(CTRL, {29'd0, intEn, 2'b01});
        st    = '0;
        polls = 0;
        while (!st[1] && polls < DONE_POLLS && !hung) begin
            if (withWindow && $random(seed) % 2 != 0) windowExercise();
            readReg(STATUS, st);
            polls++;
        end
        if (!st[1]) begin
            $display("transfer of %0d bytes did not finish within %0d status polls",
                     count, DONE_POLLS);
            errors++;
            hung = 1'b1;
            return;
        end
        if (logAddr.size() - logBase != expAddr.size()) begin
            $display("transfer wrote %0d words where %0d were expected",
                     logAddr.size() - logBase, expAddr.size());
            errors++;
        end
        for (int i = 0; i < expAddr.size() && logBase + i < logAddr.size(); i++) begin
            checkWord("write address", expAddr[i], logAddr[logBase + i]);
            checkByteEn("byte enable", expEn[i], logEn[logBase + i]);
            checkWord("memory word", expData[i], readMem(expAddr[i]));
        end
        checkFlag("irq after done", intEn, irq);
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        errAtStart = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors > errAtStart) begin
            testsFailed++;
            $display("test %s: %0d errors", curTest, errors - errAtStart);
        end else begin
            $display("test %s: ok", curTest);
        end
    endtask

    initial begin : mainSeq
        wordT a;
        wordT c;
        wordT rd;
        byteT b;
        int   lat;
        nAS_        = 1'b0;
        regValid    = 1'b0;
        regWrite    = 1'b0;
        regAddr     = '0;
        regWdata    = '0;
        scsiInt     = 1'b0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        hung        = 1'b0;
        for (int i = 0; i < STREAM_LEN; i++) streamMem[i] = byteT'($random(seed));
        repeat (2) @(posedge nSCLK);
        #1;
        nAS_ = 1'b1;

        startTest("registerReadback");
        a = $random(seed);
        c = $random(seed);
        writeReg(ADDR, a);
        writeReg(COUNT, c);
        regAccess(1'b0, ADDR, '0, rd, lat);
        checkWord("ADDR", a, rd);
        checkWord("register latency", 32'd0, wordT'(lat));    // Ready in the next cycle
        readReg(COUNT, rd);
        checkWord("COUNT", c, rd);
        for (int i = 5; i < 8; i++) begin
            readReg(3'(i), rd);
            checkWord("unused index", '0, rd);
        end
        endTest();

        startTest("windowAccess");
        b = byteT'($random(seed));
        regAccess(1'b1, WINDOW, {24'd0, b}, rd, lat);
        checkByte("chip register", b, chipReg);
        regAccess(1'b0, WINDOW, '0, rd, lat);
        checkByte("window read", b, rd[7:0]);
        checkWord("window latency", wordT'(`DMAC_PORT_CYCLES + 2), wordT'(lat));
        endTest();

        startTest("alignedTransfer");
        runTransfer(3, 4 * (1 + (($random(seed) & 32'h7))), 1'b0, 1'b0);
        endTest();

        startTest("shortTransfer");
        runTransfer(4, 4 * (1 + ($random(seed) & 32'h3)) + 1 + ($random(seed) & 32'h1),
                    1'b0, 1'b0);
        runTransfer(7, 4 * (1 + ($random(seed) & 32'h3)) + 3, 1'b0, 1'b0);
        endTest();

        startTest("windowDuringTransfer");
        runTransfer(5, 24 + ($random(seed) & 32'hF), 1'b0, 1'b1);
        endTest();

        startTest("doneAndIrq");
        runTransfer(6, 5 + ($random(seed) & 32'h7), 1'b1, 1'b0);
        readReg(STATUS, rd);
        checkFlag("done bit", 1'b1, rd[1]);
        checkFlag("irq with done", 1'b1, irq);
        writeReg(STATUS, 32'h2);    // Clear done
        readReg(STATUS, rd);
        checkFlag("done after clear", 1'b0, rd[1]);
        checkFlag("irq after clear", 1'b0, irq);
        scsiInt = 1'b1;
        @(posedge nSCLK);
        #1;
        checkFlag("irq from chip interrupt", 1'b1, irq);
        readReg(STATUS, rd);
        checkFlag("chip interrupt bit", 1'b1, rd[2]);
        writeReg(CTRL, 32'h0);    // Interrupt enable off
        checkFlag("irq while disabled", 1'b0, irq);
        scsiInt = 1'b0;
        endTest();

        $display("tests: %0d run, %0d failed, %0d errors, %0d strobe errors",
                 testsRun, testsFailed, errors, strobeErrors);
        if (errors == 0 && strobeErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- resdmac.f
+incdir+include
src/dmacPkg.sv
src/portBusIf.sv
src/portArbiter.sv
src/dmaRegisters.sv
src/byteFifo.sv
src/scsiDmaEngine.sv
src/busMaster.sv
src/resdmac.sv
tests/tbResdmac.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbResdmac
FILELIST  ?= resdmac.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
